//--- hdl/frontend_pkg.sv
package frontend_pkg;

  localparam int NUM_SUPER = 2;
  localparam int ARCH_REGS = 32;
  localparam int PHYS_REGS = 64;
  localparam int PREG_W    = 6;
  localparam int CNT_W     = PREG_W + 1;  // counts 0 to PHYS_REGS
  localparam int FB_DEPTH  = 4;
  localparam int FB_PTR_W  = $clog2(FB_DEPTH);

  localparam logic [4:0]  ZERO_REG  = 5'd31;
  localparam logic [31:0] NOOP_INST = 32'h47ff041f;  // bis $31,$31,$31

  // primary opcodes, everything else decodes as illegal
  typedef enum logic [5:0] {
    PAL_INST  = 6'h00,
    LDA_INST  = 6'h08,
    INTA_GRP  = 6'h10,
    INTL_GRP  = 6'h11,
    INTS_GRP  = 6'h12,
    INTM_GRP  = 6'h13,
    JSR_GRP   = 6'h1a,
    LDQ_INST  = 6'h29,
    STQ_INST  = 6'h2d,
    BR_INST   = 6'h30,
    BSR_INST  = 6'h34,
    BLBC_INST = 6'h38,
    BEQ_INST  = 6'h39,
    BLT_INST  = 6'h3a,
    BLE_INST  = 6'h3b,
    BLBS_INST = 6'h3c,
    BNE_INST  = 6'h3d,
    BGE_INST  = 6'h3e,
    BGT_INST  = 6'h3f
  } opcode_e;

  // operate function codes; 0x20 is addq, bis or mulq depending on group
  typedef enum logic [6:0] {
    FN_AND           = 7'h00,
    FN_BIC           = 7'h08,
    FN_CMPULT        = 7'h1d,
    FN_ADDQ_BIS_MULQ = 7'h20,
    FN_ORNOT         = 7'h28,
    FN_SUBQ          = 7'h29,
    FN_CMPEQ         = 7'h2d,
    FN_SRL           = 7'h34,
    FN_SLL           = 7'h39,
    FN_SRA           = 7'h3c,
    FN_CMPULE        = 7'h3d,
    FN_XOR           = 7'h40,
    FN_EQV           = 7'h48,
    FN_CMPLT         = 7'h4d,
    FN_CMPLE         = 7'h6d
  } int_func_e;

  typedef enum logic [25:0] {
    PAL_WHAMI = 26'h00003c,
    PAL_HALT  = 26'h000555
  } pal_func_e;

  typedef enum logic [4:0] {
    ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
    ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
    ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT, ALU_CMPULE
  } alu_func_e;

  // five units need a third bit
  typedef enum logic [2:0] {FU_ALU, FU_MULT, FU_LD, FU_ST, FU_BR} fu_e;

  typedef enum logic [1:0] {
    ALU_OPA_IS_REGA, ALU_OPA_IS_MEM_DISP, ALU_OPA_IS_NPC, ALU_OPA_IS_NOT3
  } opa_sel_e;

  typedef enum logic [1:0] {
    ALU_OPB_IS_REGB, ALU_OPB_IS_ALU_IMM, ALU_OPB_IS_BR_DISP
  } opb_sel_e;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rega_idx;
    logic [4:0]  regb_idx;
    logic [15:0] mem_disp;
  } mem_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rega_idx;
    logic [20:0] branch_disp;
  } br_fmt_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rega_idx;
    logic [4:0] regb_idx;
    logic [2:0] sbz;
    logic       imm;  // low in register form
    logic [6:0] func;
    logic [4:0] regc_idx;
  } rop_fmt_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rega_idx;
    logic [7:0] lit;
    logic       imm;
    logic [6:0] func;
    logic [4:0] regc_idx;
  } iop_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] func;
  } pal_fmt_t;

  typedef union packed {
    mem_fmt_t m;
    br_fmt_t  b;
    rop_fmt_t r;
    iop_fmt_t i;
    pal_fmt_t p;
  } inst_t;

  typedef struct packed {
    logic                         valid;
    inst_t [NUM_SUPER-1:0]        inst;
    logic  [NUM_SUPER-1:0][63:0]  pc;
    logic  [NUM_SUPER-1:0][63:0]  npc;
    logic  [NUM_SUPER-1:0][63:0]  target;  // predicted
  } fb_pair_t;

  typedef struct packed {
    logic        valid;
    logic        halt;
    logic        cpuid;
    logic        illegal;
    inst_t       inst;
    logic [63:0] pc;
    logic [63:0] npc;
    logic [63:0] target;
    opa_sel_e    opa_sel;
    opb_sel_e    opb_sel;
    alu_func_e   func;
    fu_e         fu;
    logic        rd_mem;
    logic        wr_mem;
    logic        cond_branch;
    logic        uncond_branch;
    logic [4:0]  dest_idx;
    logic [4:0]  rega_idx;
    logic [4:0]  regb_idx;
  } dec_inst_t;

  typedef struct packed {
    dec_inst_t         dec;
    logic [PREG_W-1:0] dest_tag;
    logic [PREG_W-1:0] old_dest_tag;  // freed when this slot retires
    logic [PREG_W-1:0] rega_tag;
    logic [PREG_W-1:0] regb_tag;
  } dispatch_t;

  typedef struct packed {
    logic              valid;
    logic [PREG_W-1:0] tag;
  } release_t;

endpackage

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer
  import frontend_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  input  logic     fetch_valid,
  input  fb_pair_t fetch_pair,
  input  logic     pop,
  output fb_pair_t head,
  output logic     fb_full
);

  fb_pair_t            mem [FB_DEPTH];
  logic [FB_PTR_W-1:0] head_ptr;
  logic [FB_PTR_W-1:0] tail_ptr;
  logic [FB_PTR_W:0]   count;
  logic                push;
  logic                do_pop;

  assign fb_full = int'(count) == FB_DEPTH;
  assign push    = fetch_valid && !fb_full;  // dropped when full
  assign do_pop  = pop && count != '0;

  always_comb begin
    head       = mem[head_ptr];
    head.valid = count != '0;
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[tail_ptr] <= fetch_pair;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      head_ptr <= head_ptr + FB_PTR_W'(do_pop);  // wraps, depth is a power of two
      tail_ptr <= tail_ptr + FB_PTR_W'(push);
      count    <= count + (FB_PTR_W + 1)'(push) - (FB_PTR_W + 1)'(do_pop);
    end
  end

  // fetch has to watch fb_full
  assert property (@(posedge clock) disable iff (!arst_n) fetch_valid |-> !fb_full);

  // rename only pops a pair it has seen
  assert property (@(posedge clock) disable iff (!arst_n) pop |-> count != '0);

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
  import frontend_pkg::*;
(
  input  logic        valid_in,
  input  inst_t       inst_in,
  input  logic [63:0] pc_in,
  input  logic [63:0] npc_in,
  input  logic [63:0] target_in,
  output dec_inst_t   slot
);

  logic bad;  // unknown opcode or function

  always_comb begin
    slot          = '0;
    slot.inst     = NOOP_INST;
    slot.opa_sel  = ALU_OPA_IS_REGA;
    slot.opb_sel  = ALU_OPB_IS_REGB;
    slot.func     = ALU_ADDQ;
    slot.fu       = FU_ALU;
    slot.dest_idx = ZERO_REG;
    slot.rega_idx = ZERO_REG;
    slot.regb_idx = ZERO_REG;
    bad           = 1'b0;
    if (valid_in) begin
      slot.valid  = 1'b1;
      slot.inst   = inst_in;
      slot.pc     = pc_in;
      slot.npc    = npc_in;
      slot.target = target_in;
      case (inst_in.m.opcode)
        PAL_INST: begin
          case (inst_in.p.func)
            PAL_HALT: begin
              slot.halt = 1'b1;
            end
            PAL_WHAMI: begin
              slot.cpuid    = 1'b1;
              slot.dest_idx = inst_in.r.rega_idx;
            end
            default: begin
              bad = 1'b1;
            end
          endcase
        end

        LDA_INST: begin
          slot.opa_sel  = ALU_OPA_IS_MEM_DISP;
          slot.dest_idx = inst_in.m.rega_idx;
          slot.regb_idx = inst_in.m.regb_idx;  // base
        end

        INTA_GRP, INTL_GRP, INTS_GRP, INTM_GRP: begin
          slot.opb_sel  = inst_in.i.imm ? ALU_OPB_IS_ALU_IMM : ALU_OPB_IS_REGB;
          slot.dest_idx = inst_in.r.regc_idx;
          slot.rega_idx = inst_in.r.rega_idx;
          slot.regb_idx = inst_in.i.imm ? ZERO_REG : inst_in.r.regb_idx;
          // function codes overlap between groups, so match both fields
          case ({inst_in.r.opcode, inst_in.r.func})
            {INTA_GRP, FN_ADDQ_BIS_MULQ}: slot.func = ALU_ADDQ;
            {INTA_GRP, FN_SUBQ}:          slot.func = ALU_SUBQ;
            {INTA_GRP, FN_CMPEQ}:         slot.func = ALU_CMPEQ;
            {INTA_GRP, FN_CMPLT}:         slot.func = ALU_CMPLT;
            {INTA_GRP, FN_CMPLE}:         slot.func = ALU_CMPLE;
            {INTA_GRP, FN_CMPULT}:        slot.func = ALU_CMPULT;
            {INTA_GRP, FN_CMPULE}:        slot.func = ALU_CMPULE;
            {INTL_GRP, FN_AND}:           slot.func = ALU_AND;
            {INTL_GRP, FN_BIC}:           slot.func = ALU_BIC;
            {INTL_GRP, FN_ADDQ_BIS_MULQ}: slot.func = ALU_BIS;
            {INTL_GRP, FN_ORNOT}:         slot.func = ALU_ORNOT;
            {INTL_GRP, FN_XOR}:           slot.func = ALU_XOR;
            {INTL_GRP, FN_EQV}:           slot.func = ALU_EQV;
            {INTS_GRP, FN_SRL}:           slot.func = ALU_SRL;
            {INTS_GRP, FN_SLL}:           slot.func = ALU_SLL;
            {INTS_GRP, FN_SRA}:           slot.func = ALU_SRA;
            {INTM_GRP, FN_ADDQ_BIS_MULQ}: begin
              slot.func = ALU_MULQ;
              slot.fu   = FU_MULT;
            end
            default: begin
              bad = 1'b1;
            end
          endcase
        end

        LDQ_INST: begin
          slot.opa_sel  = ALU_OPA_IS_MEM_DISP;
          slot.dest_idx = inst_in.m.rega_idx;
          slot.regb_idx = inst_in.m.regb_idx;
          slot.rd_mem   = 1'b1;
          slot.fu       = FU_LD;
        end

        STQ_INST: begin
          slot.opa_sel  = ALU_OPA_IS_MEM_DISP;
          slot.rega_idx = inst_in.m.rega_idx;  // store data
          slot.regb_idx = inst_in.m.regb_idx;
          slot.wr_mem   = 1'b1;
          slot.fu       = FU_ST;
        end

        BR_INST, BSR_INST: begin
          slot.opa_sel       = ALU_OPA_IS_NPC;
          slot.opb_sel       = ALU_OPB_IS_BR_DISP;
          slot.dest_idx      = inst_in.b.rega_idx;  // link register
          slot.uncond_branch = 1'b1;
          slot.fu            = FU_BR;
        end

        BLBC_INST, BEQ_INST, BLT_INST, BLE_INST,
        BLBS_INST, BNE_INST, BGE_INST, BGT_INST: begin
          slot.opa_sel     = ALU_OPA_IS_NPC;
          slot.opb_sel     = ALU_OPB_IS_BR_DISP;
          slot.rega_idx    = inst_in.b.rega_idx;
          slot.cond_branch = 1'b1;
          slot.fu          = FU_BR;
        end

        JSR_GRP: begin
          // jmp, jsr, ret and jsr_co all behave alike here
          slot.opa_sel       = ALU_OPA_IS_NOT3;
          slot.func          = ALU_AND;  // word-align the target
          slot.dest_idx      = inst_in.m.rega_idx;
          slot.regb_idx      = inst_in.m.regb_idx;
          slot.uncond_branch = 1'b1;
          slot.fu            = FU_BR;
        end

        default: begin
          bad = 1'b1;
        end
      endcase

      if (bad) begin
        slot.illegal = 1'b1;
        slot.valid   = 1'b0;
      end
    end
  end

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder
  import frontend_pkg::*;
(
  input  fb_pair_t                  fb_head,
  output dec_inst_t [NUM_SUPER-1:0] dec,
  output logic                      illegal
);

  // both slots share the pair valid bit
  inst_decoder i_slot0 (
    .valid_in  (fb_head.valid),
    .inst_in   (fb_head.inst[0]),
    .pc_in     (fb_head.pc[0]),
    .npc_in    (fb_head.npc[0]),
    .target_in (fb_head.target[0]),
    .slot      (dec[0])
  );

  inst_decoder i_slot1 (
    .valid_in  (fb_head.valid),
    .inst_in   (fb_head.inst[1]),
    .pc_in     (fb_head.pc[1]),
    .npc_in    (fb_head.npc[1]),
    .target_in (fb_head.target[1]),
    .slot      (dec[1])
  );

  assign illegal = dec[0].illegal | dec[1].illegal;

endmodule

//--- hdl/free_list.sv
`timescale 1ns/1ps

module free_list
  import frontend_pkg::*;
(
  input  logic                             clock,
  input  logic                             arst_n,
  input  logic     [NUM_SUPER-1:0]             alloc_req,
  input  logic                             alloc_en,
  output logic     [NUM_SUPER-1:0][PREG_W-1:0] alloc_tag,
  output logic     [CNT_W-1:0]                 free_count,
  input  release_t [NUM_SUPER-1:0]             release_tags  // from retirement
);

  logic [PREG_W-1:0] queue [PHYS_REGS];
  logic [PREG_W-1:0] head_ptr;
  logic [PREG_W-1:0] tail_ptr;
  logic [CNT_W-1:0]  count;
  logic [1:0]        n_alloc;
  logic [1:0]        n_rel;

  assign free_count   = count;
  assign alloc_tag[0] = queue[head_ptr];
  assign alloc_tag[1] = alloc_req[0] ? queue[head_ptr + 1'b1] : queue[head_ptr];

  assign n_alloc = alloc_en ? {1'b0, alloc_req[0]} + {1'b0, alloc_req[1]} : 2'd0;
  assign n_rel   = {1'b0, release_tags[0].valid} + {1'b0, release_tags[1].valid};

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        queue[i] <= PREG_W'(i + ARCH_REGS);  // only the first 32 count
      end
      head_ptr <= '0;
      tail_ptr <= PREG_W'(ARCH_REGS);
      count    <= CNT_W'(PHYS_REGS - ARCH_REGS);
    end else begin
      if (release_tags[0].valid) begin
        queue[tail_ptr] <= release_tags[0].tag;
      end
      if (release_tags[1].valid) begin
        queue[tail_ptr + PREG_W'(release_tags[0].valid)] <= release_tags[1].tag;
      end
      head_ptr <= head_ptr + PREG_W'(n_alloc);
      tail_ptr <= tail_ptr + PREG_W'(n_rel);
      count    <= count - CNT_W'(n_alloc) + CNT_W'(n_rel);
    end
  end

  // more releases than allocations would mean a tag freed twice
  assert property (@(posedge clock) disable iff (!arst_n) free_count <= PHYS_REGS);

  // rename has to stall rather than overdraw
  assert property (@(posedge clock) disable iff (!arst_n) alloc_en |-> CNT_W'(n_alloc) <= count);

endmodule

//--- hdl/rename_stage.sv
`timescale 1ns/1ps

module rename_stage
  import frontend_pkg::*;
(
  input  logic                                 clock,
  input  logic                                 arst_n,
  input  dec_inst_t [NUM_SUPER-1:0]             dec,
  input  logic                                 dec_illegal,
  input  logic      [CNT_W-1:0]                 free_count,
  input  logic      [NUM_SUPER-1:0][PREG_W-1:0] alloc_tag,
  output logic      [NUM_SUPER-1:0]             alloc_req,
  output logic                                 alloc_en,
  output logic                                 pop,
  output logic                                 stall,
  output dispatch_t [NUM_SUPER-1:0]             dispatch,
  output logic                                 halt,
  output logic                                 illegal
);

  logic      [PREG_W-1:0]    map_table [ARCH_REGS];
  logic      [1:0]           n_req;
  logic                      pair_valid;
  dispatch_t [NUM_SUPER-1:0] renamed;
  dispatch_t [NUM_SUPER-1:0] disp_q;
  logic      [NUM_SUPER-1:0] disp_valid;

  // a present slot decodes either valid or illegal
  assign pair_valid = dec[0].valid | dec[0].illegal | dec[1].valid | dec[1].illegal;

  always_comb begin
    for (int s = 0; s < NUM_SUPER; s++) begin
      alloc_req[s] = dec[s].valid && dec[s].dest_idx != ZERO_REG;
    end
  end

  assign n_req    = {1'b0, alloc_req[0]} + {1'b0, alloc_req[1]};
  assign stall    = pair_valid && free_count < CNT_W'(n_req);
  assign pop      = pair_valid && !stall;
  assign alloc_en = pop;

  always_comb begin
    for (int s = 0; s < NUM_SUPER; s++) begin
      renamed[s].dec          = dec[s];
      renamed[s].rega_tag     = map_table[dec[s].rega_idx];
      renamed[s].regb_tag     = map_table[dec[s].regb_idx];
      renamed[s].old_dest_tag = map_table[dec[s].dest_idx];
    end
    // slot 1 sees slot 0's new mapping
    if (alloc_req[0]) begin
      if (dec[1].rega_idx == dec[0].dest_idx) begin
        renamed[1].rega_tag = alloc_tag[0];
      end
      if (dec[1].regb_idx == dec[0].dest_idx) begin
        renamed[1].regb_tag = alloc_tag[0];
      end
      if (dec[1].dest_idx == dec[0].dest_idx) begin
        renamed[1].old_dest_tag = alloc_tag[0];
      end
    end
    for (int s = 0; s < NUM_SUPER; s++) begin
      renamed[s].dest_tag = alloc_req[s] ? alloc_tag[s] : renamed[s].old_dest_tag;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_table[i] <= PREG_W'(i);
      end
      disp_valid <= '0;
      halt       <= 1'b0;
      illegal    <= 1'b0;
    end else begin
      disp_valid <= '0;
      halt       <= 1'b0;
      illegal    <= 1'b0;
      if (pop) begin
        // slot 1 written last, so it wins on a shared destination
        for (int s = 0; s < NUM_SUPER; s++) begin
          if (alloc_req[s]) begin
            map_table[dec[s].dest_idx] <= alloc_tag[s];
          end
        end
        disp_valid <= {dec[1].valid, dec[0].valid};
        halt       <= dec[0].halt | dec[1].halt;
        illegal    <= dec_illegal;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      disp_q <= renamed;
    end
  end

  always_comb begin
    dispatch = disp_q;
    for (int s = 0; s < NUM_SUPER; s++) begin
      dispatch[s].dec.valid = disp_valid[s];
    end
  end

  // a stalled pair waits at the head of the fetch buffer
  assert property (@(posedge clock) disable iff (!arst_n) stall |=> $stable(dec));

endmodule

//--- hdl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top
  import frontend_pkg::*;
(
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      fetch_valid,
  input  fb_pair_t                  fetch_pair,
  output logic                      fb_full,
  input  release_t  [NUM_SUPER-1:0] release_tags,
  output dispatch_t [NUM_SUPER-1:0] dispatch,
  output logic                      halt,
  output logic                      illegal,
  output logic                      stall
);

  fb_pair_t                         fb_head;
  dec_inst_t [NUM_SUPER-1:0]             dec;
  logic                             dec_illegal;
  logic                             pop;
  logic                             alloc_en;
  logic      [NUM_SUPER-1:0]             alloc_req;
  logic      [NUM_SUPER-1:0][PREG_W-1:0] alloc_tag;
  logic      [CNT_W-1:0]                 free_count;

  fetch_buffer i_fetch_buffer (
    .clock       (clock),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_pair  (fetch_pair),
    .pop         (pop),
    .head        (fb_head),
    .fb_full     (fb_full)
  );

  decoder i_decoder (
    .fb_head (fb_head),
    .dec     (dec),
    .illegal (dec_illegal)
  );

  free_list i_free_list (
    .clock        (clock),
    .arst_n       (arst_n),
    .alloc_req    (alloc_req),
    .alloc_en     (alloc_en),
    .alloc_tag    (alloc_tag),
    .free_count   (free_count),
    .release_tags (release_tags)
  );

  rename_stage i_rename_stage (
    .clock       (clock),
    .arst_n      (arst_n),
    .dec         (dec),
    .dec_illegal (dec_illegal),
    .free_count  (free_count),
    .alloc_tag   (alloc_tag),
    .alloc_req   (alloc_req),
    .alloc_en    (alloc_en),
    .pop         (pop),
    .stall       (stall),
    .dispatch    (dispatch),
    .halt        (halt),
    .illegal     (illegal)
  );

endmodule

//--- verification/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb
  import frontend_pkg::*;
;

  // expected decode of one slot, flags are {rd_mem, wr_mem, cond, uncond}
  typedef struct packed {
    logic       valid;
    logic       illegal;
    fu_e        fu;
    alu_func_e  func;
    opa_sel_e   opa;
    opb_sel_e   opb;
    logic [3:0] flags;
    logic [4:0] dest;
    logic [4:0] rega;
    logic [4:0] regb;
  } exp_t;

  typedef struct packed {
    logic [31:0] inst0;
    logic [31:0] inst1;
    release_t    rel;
    logic        halt;
    exp_t        exp0;
    exp_t        exp1;
  } row_t;

  logic                      clock;
  logic                      arst_n;
  logic                      fetch_valid;
  fb_pair_t                  fetch_pair;
  logic                      fb_full;
  release_t  [NUM_SUPER-1:0] release_tags;
  dispatch_t [NUM_SUPER-1:0] dispatch;
  logic                      halt;
  logic                      illegal;
  logic                      stall;

  row_t        rows [10];
  int          map_m [ARCH_REGS];  // model map table
  int          fq [$];             // model free queue
  int          errors;
  int          checks;
  int unsigned max_wait = 50;
  exp_t        fill0;
  exp_t        fill1;
  exp_t        fill_z;
  event        timeout_ev;
  string       timeout_why;

  frontend_top i_dut (
    .clock        (clock),
    .arst_n       (arst_n),
    .fetch_valid  (fetch_valid),
    .fetch_pair   (fetch_pair),
    .fb_full      (fb_full),
    .release_tags (release_tags),
    .dispatch     (dispatch),
    .halt         (halt),
    .illegal      (illegal),
    .stall        (stall)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] rop(logic [5:0] op, logic [4:0] ra, logic [4:0] rb,
                                      logic [6:0] fn, logic [4:0] rc);
    return {op, ra, rb, 3'b000, 1'b0, fn, rc};
  endfunction

  function automatic logic [31:0] iop(logic [5:0] op, logic [4:0] ra, logic [7:0] lit,
                                      logic [6:0] fn, logic [4:0] rc);
    return {op, ra, lit, 1'b1, fn, rc};
  endfunction

  function automatic logic [31:0] mem(logic [5:0] op, logic [4:0] ra, logic [4:0] rb,
                                      logic [15:0] disp);
    return {op, ra, rb, disp};
  endfunction

  function automatic logic [31:0] brf(logic [5:0] op, logic [4:0] ra, logic [20:0] disp);
    return {op, ra, disp};
  endfunction

  function automatic exp_t mk(logic v, logic ill, fu_e fu, alu_func_e fn, opa_sel_e oa,
                              opb_sel_e ob, logic [3:0] fl, logic [4:0] d, logic [4:0] a,
                              logic [4:0] b);
    exp_t e;
    e = '{v, ill, fu, fn, oa, ob, fl, d, a, b};
    return e;
  endfunction

  function automatic exp_t bad_slot();
    return mk(1'b0, 1'b1, FU_ALU, ALU_ADDQ, ALU_OPA_IS_REGA, ALU_OPB_IS_REGB, 4'b0, 5'd31,
              5'd31, 5'd31);
  endfunction

  function automatic exp_t alu(alu_func_e fn, opb_sel_e ob, logic [4:0] d, logic [4:0] a,
                               logic [4:0] b);
    return mk(1'b1, 1'b0, FU_ALU, fn, ALU_OPA_IS_REGA, ob, 4'b0, d, a, b);
  endfunction

  task automatic check(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic give_up(string why);
    timeout_why = why;
    -> timeout_ev;
  endtask

  // a wait loop that ran out of time ends the run here
  initial begin
    @(timeout_ev);
    $display("timeout while waiting for %s", timeout_why);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic wait_output(string why);
    int unsigned n;
    n = 0;
    while (!(dispatch[0].dec.valid || dispatch[1].dec.valid || illegal || halt)) begin
      if (n == max_wait) begin
        give_up(why);
      end
      @(negedge clock);
      n++;
    end
  endtask

  // drives one pair for one cycle, ends on a falling edge
  task automatic send_pair(logic [31:0] i0, logic [31:0] i1, release_t rel);
    @(negedge clock);
    fetch_pair           = '0;
    fetch_pair.valid     = 1'b1;
    fetch_pair.inst[0]   = i0;
    fetch_pair.inst[1]   = i1;
    fetch_pair.pc[0]     = 64'h1000;
    fetch_pair.pc[1]     = 64'h1004;
    fetch_pair.npc[0]    = 64'h1004;
    fetch_pair.npc[1]    = 64'h1008;
    fetch_valid          = 1'b1;
    release_tags[0]      = rel;
    if (rel.valid) begin
      fq.push_back(int'(rel.tag));
    end
    @(negedge clock);
    fetch_valid  = 1'b0;
    release_tags = '0;
  endtask

  task automatic check_slot(int s, exp_t e);
    dispatch_t d;
    int        tn;
    string     p;
    d = dispatch[s];
    p = $sformatf("slot%0d", s);
    check({p, " valid"}, 64'(d.dec.valid), 64'(e.valid));
    check({p, " illegal"}, 64'(d.dec.illegal), 64'(e.illegal));
    if (e.valid) begin
      check({p, " fu"}, 64'(d.dec.fu), 64'(e.fu));
      check({p, " func"}, 64'(d.dec.func), 64'(e.func));
      check({p, " opa_sel"}, 64'(d.dec.opa_sel), 64'(e.opa));
      check({p, " opb_sel"}, 64'(d.dec.opb_sel), 64'(e.opb));
      check({p, " flags"}, 64'({d.dec.rd_mem, d.dec.wr_mem, d.dec.cond_branch,
                                d.dec.uncond_branch}), 64'(e.flags));
      check({p, " dest_idx"}, 64'(d.dec.dest_idx), 64'(e.dest));
      check({p, " rega_idx"}, 64'(d.dec.rega_idx), 64'(e.rega));
      check({p, " regb_idx"}, 64'(d.dec.regb_idx), 64'(e.regb));
      check({p, " rega_tag"}, 64'(d.rega_tag), 64'(map_m[e.rega]));
      check({p, " regb_tag"}, 64'(d.regb_tag), 64'(map_m[e.regb]));
      check({p, " old_dest_tag"}, 64'(d.old_dest_tag), 64'(map_m[e.dest]));
      if (e.dest != ZERO_REG) begin
        tn = fq.pop_front();
        check({p, " dest_tag"}, 64'(d.dest_tag), 64'(tn));
        map_m[e.dest] = tn;
      end
    end
  endtask

  task automatic check_pair(exp_t e0, exp_t e1, logic exp_halt);
    check("halt", 64'(halt), 64'(exp_halt));
    check("illegal", 64'(illegal), 64'(e0.illegal | e1.illegal));
    check_slot(0, e0);
    check_slot(1, e1);  // after slot 0, so it sees the new mapping
  endtask

  task automatic build_table();
    release_t none;
    release_t r3;
    none = '0;
    r3   = '{1'b1, 6'd3};  // r3's reset tag, replaced in row 0
    rows[0] = '{rop(6'h10, 1, 2, 7'h20, 3), iop(6'h10, 3, 8'd5, 7'h29, 4), none, 1'b0,
                alu(ALU_ADDQ, ALU_OPB_IS_REGB, 3, 1, 2),
                alu(ALU_SUBQ, ALU_OPB_IS_ALU_IMM, 4, 3, 31)};
    rows[1] = '{rop(6'h11, 4, 3, 7'h00, 5), iop(6'h11, 5, 8'd7, 7'h20, 5), none, 1'b0,
                alu(ALU_AND, ALU_OPB_IS_REGB, 5, 4, 3),
                alu(ALU_BIS, ALU_OPB_IS_ALU_IMM, 5, 5, 31)};
    rows[2] = '{rop(6'h12, 5, 1, 7'h39, 6), rop(6'h13, 6, 2, 7'h20, 7), none, 1'b0,
                alu(ALU_SLL, ALU_OPB_IS_REGB, 6, 5, 1),
                mk(1, 0, FU_MULT, ALU_MULQ, ALU_OPA_IS_REGA, ALU_OPB_IS_REGB, 4'b0, 7, 6, 2)};
    rows[3] = '{mem(6'h08, 8, 7, 16'h10), mem(6'h29, 9, 8, 16'h8), none, 1'b0,
                mk(1, 0, FU_ALU, ALU_ADDQ, ALU_OPA_IS_MEM_DISP, ALU_OPB_IS_REGB, 4'b0, 8, 31, 7),
                mk(1, 0, FU_LD, ALU_ADDQ, ALU_OPA_IS_MEM_DISP, ALU_OPB_IS_REGB, 4'b1000, 9, 31,
                   8)};
    rows[4] = '{mem(6'h2d, 9, 8, 16'h0), brf(6'h30, 26, 21'h40), none, 1'b0,
                mk(1, 0, FU_ST, ALU_ADDQ, ALU_OPA_IS_MEM_DISP, ALU_OPB_IS_REGB, 4'b0100, 31, 9,
                   8),
                mk(1, 0, FU_BR, ALU_ADDQ, ALU_OPA_IS_NPC, ALU_OPB_IS_BR_DISP, 4'b0001, 26, 31,
                   31)};
    rows[5] = '{brf(6'h39, 9, 21'h10), mem(6'h1a, 26, 27, 16'h4000), none, 1'b0,
                mk(1, 0, FU_BR, ALU_ADDQ, ALU_OPA_IS_NPC, ALU_OPB_IS_BR_DISP, 4'b0010, 31, 9,
                   31),
                mk(1, 0, FU_BR, ALU_AND, ALU_OPA_IS_NOT3, ALU_OPB_IS_REGB, 4'b0001, 26, 31, 27)};
    rows[6] = '{32'h0420_0000, rop(6'h10, 1, 1, 7'h20, 10), none, 1'b0,
                bad_slot(), alu(ALU_ADDQ, ALU_OPB_IS_REGB, 10, 1, 1)};
    rows[7] = '{rop(6'h10, 10, 2, 7'h20, 11), rop(6'h11, 11, 2, 7'h39, 12), none, 1'b0,
                alu(ALU_ADDQ, ALU_OPB_IS_REGB, 11, 10, 2), bad_slot()};
    rows[8] = '{{6'h00, 26'h00003c}, rop(6'h10, 0, 0, 7'h20, 13), r3, 1'b0,
                alu(ALU_ADDQ, ALU_OPB_IS_REGB, 0, 31, 31),
                alu(ALU_ADDQ, ALU_OPB_IS_REGB, 13, 0, 0)};
    rows[9] = '{{6'h00, 26'h000555}, NOOP_INST, none, 1'b1,
                alu(ALU_ADDQ, ALU_OPB_IS_REGB, 31, 31, 31),
                alu(ALU_BIS, ALU_OPB_IS_REGB, 31, 31, 31)};
  endtask

  initial begin
    arst_n       = 1'b0;
    fetch_valid  = 1'b0;
    fetch_pair   = '0;
    release_tags = '0;
    errors       = 0;
    checks       = 0;
    for (int i = 0; i < ARCH_REGS; i++) begin
      map_m[i] = i;
    end
    for (int t = ARCH_REGS; t < PHYS_REGS; t++) begin
      fq.push_back(t);
    end
    build_table();
    fill0  = alu(ALU_ADDQ, ALU_OPB_IS_REGB, 22, 20, 21);
    fill1  = alu(ALU_ADDQ, ALU_OPB_IS_REGB, 23, 22, 21);
    fill_z = alu(ALU_ADDQ, ALU_OPB_IS_REGB, 31, 22, 21);
    repeat (4) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;

    for (int r = 0; r < 10; r++) begin
      send_pair(rows[r].inst0, rows[r].inst1, rows[r].rel);
      wait_output($sformatf("dispatch of table row %0d", r));
      check_pair(rows[r].exp0, rows[r].exp1, rows[r].halt);
    end

    // drain the free list, an odd count ends with a one-tag pair
    while (fq.size() > 0) begin
      if (fq.size() >= 2) begin
        send_pair(rop(6'h10, 20, 21, 7'h20, 22), rop(6'h10, 22, 21, 7'h20, 23), '0);
        wait_output("dispatch of a fill pair");
        check_pair(fill0, fill1, 1'b0);
      end else begin
        send_pair(rop(6'h10, 20, 21, 7'h20, 22), rop(6'h10, 22, 21, 7'h20, 31), '0);
        wait_output("dispatch of a fill pair");
        check_pair(fill0, fill_z, 1'b0);
      end
    end

    send_pair(rop(6'h10, 20, 21, 7'h20, 22), rop(6'h10, 22, 21, 7'h20, 23), '0);
    for (int unsigned n = 0; !stall; n++) begin
      if (n == max_wait) begin
        give_up("stall with an empty free list");
      end
      @(negedge clock);
    end
    repeat (2) begin
      @(negedge clock);
      check("dispatch valid under stall", 64'({dispatch[1].dec.valid,
                                               dispatch[0].dec.valid}), 64'd0);
    end
    for (int k = 1; k < 4; k++) begin
      @(negedge clock);
      fetch_pair.inst[1] = rop(6'h10, 22, 21, 7'h20, 5'(23 + k));  // slot 1 dest marks the pair
      fetch_valid        = 1'b1;
    end
    @(negedge clock);
    fetch_valid = 1'b0;
    check("fb_full", 64'(fb_full), 64'd1);
    check("stall", 64'(stall), 64'd1);

    // two released tags per pair, pairs must leave in order
    for (int k = 0; k < 4; k++) begin
      release_tags[0] = '{1'b1, PREG_W'(2 * k)};
      release_tags[1] = '{1'b1, PREG_W'(2 * k + 1)};
      fq.push_back(2 * k);
      fq.push_back(2 * k + 1);
      @(negedge clock);
      release_tags = '0;
      wait_output($sformatf("dispatch of stalled pair %0d", k));
      check_pair(fill0, alu(ALU_ADDQ, ALU_OPB_IS_REGB, 5'(23 + k), 22, 21), 1'b0);
    end
    @(negedge clock);
    check("fb_full at end", 64'(fb_full), 64'd0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
hdl/frontend_pkg.sv
hdl/fetch_buffer.sv
hdl/inst_decoder.sv
hdl/decoder.sv
hdl/free_list.sv
hdl/rename_stage.sv
hdl/frontend_top.sv
verification/frontend_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= frontend_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)
